// File: Bender.yml
package:
  name: snow_init

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/snowPkg.sv
      - source/sBoxLayer.sv
      - source/snowFsm.sv
      - source/snowLfsr.sv
      - source/roundCounter.sv
      - source/initControl.sv
      - source/snowInit.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/snowInitTb.sv

// File: sim/snowRefModel.svh
// ============================================================
// Reference model of SNOW 3G load and initialization
// Takes only the S-box tables from snowPkg, all arithmetic is local
// Must be included after the snowPkg import
// ============================================================
`ifndef SNOW_REF_MODEL_SVH
`define SNOW_REF_MODEL_SVH

function automatic lfsrState modelLoad(logic [127:0] k, logic [127:0] v);
    lfsrState s;
    for (int j = 0; j < 4; j++) begin
        s[7 - j] = k[32 * (3 - j) +: 32];
        s[3 - j] = ~k[32 * (3 - j) +: 32];
    end
    s[15] = k[127:96] ^ v[31:0];
    s[14] = k[95:64];
    s[13] = k[63:32];
    s[12] = k[31:0] ^ v[63:32];
    s[11] = ~k[127:96];
    s[10] = ~k[95:64] ^ v[95:64];
    s[9]  = ~k[63:32] ^ v[127:96];
    s[8]  = ~k[31:0];
    return s;
endfunction

// Walks c times beta^n for n = 0..255 and picks the four needed powers
function automatic snowWord modelAlpha(logic [7:0] c, bit divide);
    int unsigned ex [4];
    logic [7:0]  p;
    snowWord     w;
    if (divide) begin
        ex = '{16, 39, 6, 64};
    end else begin
        ex = '{23, 245, 48, 239};
    end
    p = c;
    w = '0;
    for (int n = 0; n < 256; n++) begin
        for (int b = 0; b < 4; b++) begin
            if (ex[b] == n) begin
                w[31 - 8 * b -: 8] = p;
            end
        end
        p = {p[6:0], 1'b0} ^ (p[7] ? 8'ha9 : 8'h00);
    end
    return w;
endfunction

// Byte 0 is the top byte; doubling is linear, so 2a ^ 3b = 2(a ^ b) ^ b
function automatic snowWord modelSbox(snowWord w, bit sq);
    logic [7:0] t [4];
    logic [7:0] poly;
    logic [7:0] d;
    snowWord    r;
    poly = sq ? 8'h69 : 8'h1b;
    for (int j = 0; j < 4; j++) begin
        t[j] = sq ? sBoxSQ[w[31 - 8 * j -: 8]] : sBoxSR[w[31 - 8 * j -: 8]];
    end
    for (int j = 0; j < 4; j++) begin
        d = t[j] ^ t[(j + 3) % 4];
        d = {d[6:0], 1'b0} ^ (d[7] ? poly : 8'h00);
        r[31 - 8 * j -: 8] = d ^ t[(j + 3) % 4] ^ t[(j + 1) % 4] ^ t[(j + 2) % 4];
    end
    return r;
endfunction

task automatic modelRun(input logic [127:0] k, input logic [127:0] v,
                        output lfsrState sOut, output fsmState fOut);
    lfsrState s;
    snowWord  r1;
    snowWord  r2;
    snowWord  r3;
    snowWord  f;
    snowWord  r;
    snowWord  fb;
    s  = modelLoad(k, v);
    r1 = '0;
    r2 = '0;
    r3 = '0;
    for (int n = 0; n < initRounds; n++) begin
        f  = (s[15] + r1) ^ r2;
        r  = r2 + (r3 ^ s[5]);
        r3 = modelSbox(r2, 1'b1);
        r2 = modelSbox(r1, 1'b0);
        r1 = r;
        fb = {s[0][23:0], 8'h00} ^ modelAlpha(s[0][31:24], 1'b0) ^ s[2]
           ^ (s[11] >> 8) ^ modelAlpha(s[11][7:0], 1'b1) ^ f;
        for (int i = 0; i < 15; i++) begin
            s[i] = s[i + 1];
        end
        s[15] = fb;
    end
    sOut = s;
    fOut = {r3, r2, r1};
endtask

`endif

// File: sim/snowInitTb.sv
// ============================================================
// Testbench for the SNOW 3G initialization core
// Keys and IVs come from a fixed-seed xorshift generator
// Inputs change on the falling edge, outputs are read there too
// ============================================================
`timescale 1ns/1ps

module snowInitTb
    import snowPkg::*;
();

    localparam int clkPeriod   = 40;
    localparam int resetCycles = 10;
    localparam int randomRuns  = 30;
    localparam int holdCycles  = 20;
    // 40 sequences of 40 cycles, plus some margin
    localparam int watchdogTime = (40 * 40 + 100) * clkPeriod;

    logic         clk;
    logic         reset;
    logic         load;
    logic [127:0] key;
    logic [127:0] iv;
    lfsrState     lfsrOut;
    fsmState      fsmOut;
    logic         done;

    int          lfsrErrors = 0;
    int          fsmErrors  = 0;
    int          doneErrors = 0;
    logic [31:0] rngState;

    `include "snowRefModel.svh"

    snowInit uut (
        .clk     (clk),
        .reset   (reset),
        .load    (load),
        .key     (key),
        .iv      (iv),
        .lfsrOut (lfsrOut),
        .fsmOut  (fsmOut),
        .done    (done)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(watchdogTime);
        $display("Watchdog timeout, the run did not finish within %0d ns", watchdogTime);
        $display("Checks failed");
        $finish;
    end

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    function automatic logic [127:0] randomBlock();
        logic [127:0] b;
        for (int i = 0; i < 4; i++) begin
            b[32 * i +: 32] = nextRandom();
        end
        return b;
    endfunction

    task automatic checkLfsr(input string name, input lfsrState expected, input lfsrState actual);
        if (actual !== expected) begin
            lfsrErrors++;
            $display("MISMATCH %s lfsr expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkFsm(input string name, input fsmState expected, input fsmState actual);
        if (actual !== expected) begin
            fsmErrors++;
            $display("MISMATCH %s fsm expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkDone(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            doneErrors++;
            $display("MISMATCH %s done expected %b actual %b", name, expected, actual);
        end
    endtask

    // One-cycle strobe, returns at the falling edge after the load edge
    task automatic applyLoad(input logic [127:0] k, input logic [127:0] v);
        @(negedge clk);
        key  = k;
        iv   = v;
        load = 1'b1;
        @(negedge clk);
        load = 1'b0;
    endtask

    task automatic checkLoaded(input string name, input logic [127:0] k, input logic [127:0] v);
        checkLfsr(name, modelLoad(k, v), lfsrOut);
        checkFsm(name, '0, fsmOut);
        checkDone(name, 1'b0, done);
    endtask

    // done must stay low until exactly the last init clock
    task automatic awaitDone(input string name);
        for (int n = 1; n <= initRounds; n++) begin
            @(negedge clk);
            checkDone(name, n == initRounds, done);
        end
    endtask

    task automatic fullRun(input string name, input logic [127:0] k, input logic [127:0] v,
                           output lfsrState expL, output fsmState expF);
        applyLoad(k, v);
        checkLoaded(name, k, v);
        awaitDone(name);
        modelRun(k, v, expL, expF);
        checkLfsr(name, expL, lfsrOut);
        checkFsm(name, expF, fsmOut);
    endtask

    initial begin
        lfsrState     expL;
        fsmState      expF;
        logic [127:0] k;
        logic [127:0] v;
        logic [127:0] k2;
        logic [127:0] v2;
        rngState = 32'h38a96062;
        reset    = 1'b1;
        load     = 1'b0;
        key      = '0;
        iv       = '0;
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        checkDone("after reset", 1'b0, done);
        checkLfsr("after reset", '0, lfsrOut);
        checkFsm("after reset", '0, fsmOut);

        for (int t = 0; t < randomRuns; t++) begin
            k = randomBlock();
            v = randomBlock();
            fullRun($sformatf("random %0d", t), k, v, expL, expF);
        end

        // State must hold while idle in done
        for (int n = 0; n < holdCycles; n++) begin
            @(negedge clk);
            checkLfsr("hold", expL, lfsrOut);
            checkFsm("hold", expF, fsmOut);
            checkDone("hold", 1'b1, done);
        end

        // Second load lands 10 cycles into the first run
        k  = randomBlock();
        v  = randomBlock();
        k2 = randomBlock();
        v2 = randomBlock();
        applyLoad(k, v);
        checkLoaded("restart first", k, v);
        repeat (9) begin
            @(negedge clk);
            checkDone("restart first", 1'b0, done);
        end
        fullRun("restart second", k2, v2, expL, expF);

        k = randomBlock();
        v = randomBlock();
        fullRun("reload from done", k, v, expL, expF);

        $display("Error counts: lfsr %0d, fsm %0d, done %0d", lfsrErrors, fsmErrors, doneErrors);
        if (lfsrErrors + fsmErrors + doneErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: source/initControl.sv
// ============================================================
// Sequencer for load, the 32 init clocks and the done level
// A load in any state restarts the run at the same edge
// ============================================================
`timescale 1ns/1ps

module initControl (
    input  logic clk,
    input  logic reset,
    input  logic load,
    input  logic lastRound,
    output logic step,
    output logic counterClear,
    output logic done
);

    typedef enum logic [1:0] {
        idleState,
        runningState,
        doneState
    } ctrlState;

    ctrlState state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= idleState;
        end else if (load) begin
            state <= runningState;
        end else if (state == runningState && lastRound) begin
            state <= doneState;
        end
    end

    // Restart the count with every load
    assign counterClear = load;
    assign step         = (state == runningState);
    assign done         = (state == doneState);

endmodule

// File: source/roundCounter.sv
// ============================================================
// Counts initialization clocks since the last clear
// lastRound is combinational and high while the count is 31
// counterClear wins over step
// ============================================================
`timescale 1ns/1ps

module roundCounter
    import snowPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic counterClear,
    input  logic step,
    output logic lastRound
);

    roundCount count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (counterClear) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1;
        end
    end

    assign lastRound = (count == roundCount'(initRounds - 1));

endmodule

// File: source/sBoxLayer.sv
// ============================================================
// Combinational 32-bit S-box layer, S1 or S2 of the FSM
// useSq = 0 gives S1 (SR table, 1B), useSq = 1 gives S2 (SQ, 69)
// No registers, result is valid in the same cycle
// ============================================================
`timescale 1ns/1ps

module sBoxLayer
    import snowPkg::*;
#(
    parameter bit useSq = 1'b0
) (
    input  snowWord wordIn,
    output snowWord wordOut
);

    localparam logic [7:0] poly = useSq ? mixPolySQ : mixPolySR;

    // Index 0 is the most significant byte, as in the cipher spec
    logic [3:0][7:0] sub;
    logic [3:0][7:0] dbl;

    always_comb begin
        for (int j = 0; j < 4; j++) begin
            if (useSq) begin
                sub[j] = sBoxSQ[wordIn[31 - 8 * j -: 8]];
            end else begin
                sub[j] = sBoxSR[wordIn[31 - 8 * j -: 8]];
            end
            dbl[j] = mulX(sub[j], poly);
        end
    end

    // Column mix, r_j = 2w_j ^ 3w_(j-1) ^ w_(j+1) ^ w_(j+2)
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            wordOut[31 - 8 * j -: 8] = dbl[j] ^ dbl[(j + 3) % 4] ^ sub[(j + 3) % 4]
                                     ^ sub[(j + 1) % 4] ^ sub[(j + 2) % 4];
        end
    end

endmodule

// File: source/snowFsm.sv
// ============================================================
// SNOW 3G FSM: registers R1, R2, R3 and output word F
// load clears all three registers and wins over step
// F is combinational from the current registers and s15
// ============================================================
`timescale 1ns/1ps

module snowFsm
    import snowPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    load,
    input  logic    step,
    input  snowWord s15,
    input  snowWord s5,
    output snowWord fsmWord,
    output fsmState fsmOut
);

    snowWord r1;
    snowWord r2;
    snowWord r3;
    snowWord r1Next;
    snowWord s1Out;
    snowWord s2Out;

    sBoxLayer #(.useSq(1'b0)) s1 (.wordIn(r1), .wordOut(s1Out));
    sBoxLayer #(.useSq(1'b1)) s2 (.wordIn(r2), .wordOut(s2Out));

    // Sums wrap modulo 2^32
    assign fsmWord = (s15 + r1) ^ r2;
    assign r1Next  = r2 + (r3 ^ s5);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            r1 <= '0;
            r2 <= '0;
            r3 <= '0;
        end else if (load) begin
            r1 <= '0;
            r2 <= '0;
            r3 <= '0;
        end else if (step) begin
            r1 <= r1Next;
            r2 <= s1Out;
            r3 <= s2Out;
        end
    end

    assign fsmOut = {r3, r2, r1};

endmodule

// File: source/snowInit.sv
// ============================================================
// SNOW 3G initialization core, top level
// load is a one-cycle strobe; done rises 32 clocks after it
// Outputs are held while done is high, until the next load
// Keystream generation is not part of this core
// ============================================================
`timescale 1ns/1ps

module snowInit
    import snowPkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         load,
    input  logic [127:0] key,
    input  logic [127:0] iv,
    output lfsrState     lfsrOut,
    output fsmState      fsmOut,
    output logic         done
);

    logic    step;
    logic    counterClear;
    logic    lastRound;
    snowWord fsmWord;
    snowWord s15;
    snowWord s5;

    initControl control (
        .clk          (clk),
        .reset        (reset),
        .load         (load),
        .lastRound    (lastRound),
        .step         (step),
        .counterClear (counterClear),
        .done         (done)
    );

    roundCounter counter (
        .clk          (clk),
        .reset        (reset),
        .counterClear (counterClear),
        .step         (step),
        .lastRound    (lastRound)
    );

    snowLfsr lfsr (
        .clk     (clk),
        .reset   (reset),
        .load    (load),
        .step    (step),
        .key     (key),
        .iv      (iv),
        .fsmWord (fsmWord),
        .lfsrOut (lfsrOut),
        .s15     (s15),
        .s5      (s5)
    );

    snowFsm fsm (
        .clk     (clk),
        .reset   (reset),
        .load    (load),
        .step    (step),
        .s15     (s15),
        .s5      (s5),
        .fsmWord (fsmWord),
        .fsmOut  (fsmOut)
    );

endmodule

// File: source/snowLfsr.sv
// ============================================================
// Sixteen-word SNOW 3G LFSR in initialization mode
// load takes the key and IV pattern and wins over step
// Each step shifts s_i <= s_(i+1) and feeds v into s15
// ============================================================
`timescale 1ns/1ps

module snowLfsr
    import snowPkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         load,
    input  logic         step,
    input  logic [127:0] key,
    input  logic [127:0] iv,
    input  snowWord      fsmWord,
    output lfsrState     lfsrOut,
    output snowWord      s15,
    output snowWord      s5
);

    logic [3:0][31:0] keyWords;
    logic [3:0][31:0] ivWords;
    lfsrState         lfsr;
    lfsrState         loadPattern;
    snowWord          feedback;

    assign keyWords = key;
    assign ivWords  = iv;

    always_comb begin
        loadPattern[15] = keyWords[3] ^ ivWords[0];
        loadPattern[14] = keyWords[2];
        loadPattern[13] = keyWords[1];
        loadPattern[12] = keyWords[0] ^ ivWords[1];
        loadPattern[11] = ~keyWords[3];
        loadPattern[10] = ~keyWords[2] ^ ivWords[2];
        loadPattern[9]  = ~keyWords[1] ^ ivWords[3];
        loadPattern[8]  = ~keyWords[0];
        // Lower half is the plain and inverted key
        for (int i = 0; i < 4; i++) begin
            loadPattern[4 + i] = keyWords[i];
            loadPattern[i]     = ~keyWords[i];
        end
    end

    // v = s0*alpha ^ s2 ^ s11/alpha ^ F
    assign feedback = {lfsr[0][23:0], 8'h00} ^ mulAlpha(lfsr[0][31:24]) ^ lfsr[2]
                    ^ {8'h00, lfsr[11][31:8]} ^ divAlpha(lfsr[11][7:0]) ^ fsmWord;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= '0;
        end else if (load) begin
            lfsr <= loadPattern;
        end else if (step) begin
            lfsr <= {feedback, lfsr[lfsrWords - 1:1]};
        end
    end

    assign lfsrOut = lfsr;
    assign s15     = lfsr[15];
    assign s5      = lfsr[5];

endmodule

// File: source/snowPkg.sv
// ============================================================
// Shared types, constants and byte-field helpers for SNOW 3G
// Word width and round count are fixed by the cipher
// Alpha terms are built by byte doubling over reduction byte A9
// snowTables.svh must be reachable on the include path
// ============================================================
package snowPkg;

    localparam int unsigned lfsrWords  = 16;
    localparam int unsigned fsmWords   = 3;
    localparam int unsigned initRounds = 32;

    typedef logic [31:0] snowWord;
    typedef logic [$clog2(initRounds + 1) - 1:0] roundCount;

    // Word i at bits 32*i upward
    typedef snowWord [lfsrWords - 1:0] lfsrState;
    // R1 lowest, R3 highest
    typedef snowWord [fsmWords - 1:0] fsmState;

    localparam logic [7:0] mixPolySR = 8'h1b;
    localparam logic [7:0] mixPolySQ = 8'h69;
    localparam logic [7:0] alphaPoly = 8'ha9;

    `include "snowTables.svh"

    // One doubling step in GF(2^8) for the given reduction byte
    function automatic logic [7:0] mulX(logic [7:0] v, logic [7:0] poly);
        logic [7:0] shifted;
        shifted = {v[6:0], 1'b0};
        if (v[7]) begin
            return shifted ^ poly;
        end
        return shifted;
    endfunction

    // Repeated doubling, pow up to 255
    function automatic logic [7:0] mulXPow(logic [7:0] v, int unsigned pow,
                                           logic [7:0] poly);
        logic [7:0] acc;
        acc = v;
        for (int i = 0; i < 255; i++) begin
            if (i < pow) begin
                acc = mulX(acc, poly);
            end
        end
        return acc;
    endfunction

    // Multiply by alpha, indexed by the top byte of s0
    function automatic snowWord mulAlpha(logic [7:0] c);
        return {mulXPow(c, 23, alphaPoly), mulXPow(c, 245, alphaPoly),
                mulXPow(c, 48, alphaPoly), mulXPow(c, 239, alphaPoly)};
    endfunction

    // Divide by alpha, indexed by the low byte of s11
    function automatic snowWord divAlpha(logic [7:0] c);
        return {mulXPow(c, 16, alphaPoly), mulXPow(c, 39, alphaPoly),
                mulXPow(c, 6, alphaPoly), mulXPow(c, 64, alphaPoly)};
    endfunction

endpackage

// File: source/snowTables.svh
// ============================================================
// Byte substitution tables for the SNOW 3G FSM
// sBoxSR is the Rijndael S-box used by S1
// sBoxSQ is the Dickson-derived SQ box used by S2
// Entry 0 sits leftmost in each constant
// ============================================================
`ifndef SNOW_TABLES_SVH
`define SNOW_TABLES_SVH

localparam logic [0:255][7:0] sBoxSR = {
    128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
};

localparam logic [0:255][7:0] sBoxSQ = {
    128'h25247367d7ae5c30a4ee6ecb7db582db, 128'he48e48494f5d6a787088e85f5e8465e2,
    128'hd8e9cced402f112857d2ace34a151bb9, 128'hb28085a62e024729074b0ec151aa89d4,
    128'hca0146b3efdd447bc27fbec39f204c64, 128'h83a2684213b441cdbac6bb6d4d7121f4,
    128'h8db0e593fe8fe6cf43453122373696fa, 128'hbc0f08521d551ac54e23697a92ff5b5a,
    128'heb9a1ca9d17e0dfc508ab662f50af8dc, 128'h033c0c39f1b8f33df2d597668132a000,
    128'h06cef6eab717f78c79d6a7bf8b3f1f53, 128'h6375352c60fd27d394a57ca105582dbd,
    128'hd9c7af6b540be03804c89de714b1879c, 128'hdf6ff9da2ac459167491ab266176342b,
    128'had99fb72ec3312de983bc09b3e18103a, 128'h56e177c91e9e95a39019a86c09d0f086
};

`endif

// File: tb.f
+incdir+source
+incdir+sim
source/snowPkg.sv
source/sBoxLayer.sv
source/snowFsm.sv
source/snowLfsr.sv
source/roundCounter.sv
source/initControl.sv
source/snowInit.sv
sim/snowInitTb.sv
